// ==== design/icache_defs.svh ====
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// ==============================
// Address split
// ==============================

// Fetch address width
`define ICACHE_ADDR_BITS      16
// Byte offset inside an 8-byte block
`define ICACHE_OFFSET_BITS    3
// Block tag kept per line
`define ICACHE_TAG_BITS       12

// ==============================
// Bank geometry and memory side
// ==============================

`define ICACHE_LINES_PER_BANK 8
// Line index width, log2 of the line count
`define ICACHE_WAY_BITS       3
`define ICACHE_BLOCK_BITS     64
`define ICACHE_MEM_TAG_BITS   4
// Replacement LFSR start value, all-ones would lock up the XNOR form
`define ICACHE_LFSR_SEED      3'b101

`endif

// ==== design/icache_pkg.sv ====
`include "icache_defs.svh"

package icache_pkg;

    // Field view of a fetch address
    // Tag on top, then the bank select bit, then the byte offset
    typedef struct packed {
        logic [`ICACHE_TAG_BITS-1:0]    tag;
        logic                           bank;
        logic [`ICACHE_OFFSET_BITS-1:0] offset;
    } fetch_fields_t;

    // One fetch address word, two readings of it
    // Memory side works on raw, lookup works on fields
    typedef union packed {
        logic [`ICACHE_ADDR_BITS-1:0] raw;
        fetch_fields_t                fields;
    } fetch_addr_t;

    // Memory transaction tag
    // Zero means no transaction
    typedef logic [`ICACHE_MEM_TAG_BITS-1:0] mem_tag_t;

    // One cache block as returned by memory
    typedef logic [`ICACHE_BLOCK_BITS-1:0] mem_block_t;

endpackage

// ==== design/replace_lfsr.sv ====
`timescale 1ns/100ps
`include "icache_defs.svh"

module replace_lfsr (
    input  logic                        clock,
    input  logic                        reset,
    output logic [`ICACHE_WAY_BITS-1:0] victim_index
);

    // Shift register state
    logic [`ICACHE_WAY_BITS-1:0] lfsr_state;
    logic                        feedback;

    // XNOR taps for a 3-bit maximal sequence
    // Runs through 7 states, never reaches all ones
    assign feedback = lfsr_state[`ICACHE_WAY_BITS-1] ~^ lfsr_state[`ICACHE_WAY_BITS-2];

    // Free running, advances every cycle
    always_ff @(posedge clock) begin
        if (reset) begin
            lfsr_state <= `ICACHE_LFSR_SEED;
        end else begin
            lfsr_state <= {lfsr_state[`ICACHE_WAY_BITS-2:0], feedback};
        end
    end

    // Current state doubles as the victim line
    assign victim_index = lfsr_state;

endmodule

// ==== design/icache_bank.sv ====
`timescale 1ns/100ps
`include "icache_defs.svh"

module icache_bank (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    bank_id,
    input  icache_pkg::fetch_addr_t read_addr_0,
    input  icache_pkg::fetch_addr_t read_addr_1,
    input  logic                    read_valid_0,
    input  logic                    read_valid_1,
    input  logic                    fill_valid,
    input  icache_pkg::fetch_addr_t fill_addr,
    input  icache_pkg::mem_block_t  fill_data,
    output logic                    lookup_hit,
    output icache_pkg::mem_block_t  lookup_data,
    output logic                    served_port
);

    // ==============================
    // Line storage
    // ==============================
    logic [`ICACHE_LINES_PER_BANK-1:0] line_valid;
    logic [`ICACHE_TAG_BITS-1:0]       line_tag  [`ICACHE_LINES_PER_BANK];
    icache_pkg::mem_block_t            line_data [`ICACHE_LINES_PER_BANK];

    // Lookup side
    logic                              take_port_0;
    logic                              take_port_1;
    icache_pkg::fetch_addr_t           served_addr;
    logic [`ICACHE_LINES_PER_BANK-1:0] line_match;

    // Fill side
    logic                              fill_here;
    logic [`ICACHE_LINES_PER_BANK-1:0] fill_match;
    logic                              have_free;
    logic                              have_tag;
    logic [`ICACHE_WAY_BITS-1:0]       free_index;
    logic [`ICACHE_WAY_BITS-1:0]       tag_index;
    logic [`ICACHE_WAY_BITS-1:0]       fill_index;
    logic [`ICACHE_WAY_BITS-1:0]       victim_index;

    replace_lfsr u_replace_lfsr (
        .clock        (clock),
        .reset        (reset),
        .victim_index (victim_index)
    );

    // Port 0 has first claim on this bank
    assign take_port_0 = read_valid_0 && (read_addr_0.fields.bank == bank_id);
    assign take_port_1 = read_valid_1 && (read_addr_1.fields.bank == bank_id);
    assign served_port = ~take_port_0;
    assign served_addr = take_port_0 ? read_addr_0 : read_addr_1;

    // Fully associative compare against every line
    always_comb begin
        lookup_data = '0;
        for (int i = 0; i < `ICACHE_LINES_PER_BANK; i++) begin
            line_match[i] = line_valid[i] && (line_tag[i] == served_addr.fields.tag);
            if (line_match[i]) begin
                lookup_data = line_data[i];
            end
        end
    end

    // No hit when neither port points here
    assign lookup_hit = (take_port_0 || take_port_1) && (|line_match);

    // ==============================
    // Fill placement
    // ==============================
    assign fill_here = fill_valid && (fill_addr.fields.bank == bank_id);

    // Scan from the top so the lowest index wins
    always_comb begin
        have_free  = 1'b0;
        have_tag   = 1'b0;
        free_index = '0;
        tag_index  = '0;
        for (int i = `ICACHE_LINES_PER_BANK - 1; i >= 0; i--) begin
            fill_match[i] = line_valid[i] && (line_tag[i] == fill_addr.fields.tag);
            if (!line_valid[i]) begin
                have_free  = 1'b1;
                free_index = i[`ICACHE_WAY_BITS-1:0];
            end
            if (fill_match[i]) begin
                have_tag  = 1'b1;
                tag_index = i[`ICACHE_WAY_BITS-1:0];
            end
        end
        // Same block already present, else free line, else random victim
        if (have_tag) begin
            fill_index = tag_index;
        end else if (have_free) begin
            fill_index = free_index;
        end else begin
            fill_index = victim_index;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            line_valid <= '0;
        end else if (fill_here) begin
            line_valid[fill_index] <= 1'b1;
        end
    end

    // Tag and block written with the valid bit
    always_ff @(posedge clock) begin
        if (fill_here) begin
            line_tag[fill_index]  <= fill_addr.fields.tag;
            line_data[fill_index] <= fill_data;
        end
    end

    // Placement keeps tags unique inside the bank
    a_unique_tag: assert property (@(posedge clock) disable iff (reset)
        $onehot0(line_match) && $onehot0(fill_match));

    // Miss tracker hands over block-aligned fills only
    a_fill_aligned: assert property (@(posedge clock) disable iff (reset)
        fill_valid |-> (fill_addr.fields.offset == '0));

endmodule

// ==== design/miss_request.sv ====
`timescale 1ns/100ps
`include "icache_defs.svh"

module miss_request (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    miss_valid,
    input  icache_pkg::fetch_addr_t miss_addr,
    input  icache_pkg::mem_tag_t    mem_transaction_tag,
    input  icache_pkg::mem_tag_t    mem_data_tag,
    input  icache_pkg::mem_block_t  mem_data,
    output logic                    mem_req_valid,
    output icache_pkg::fetch_addr_t mem_req_addr,
    output logic                    fill_valid,
    output icache_pkg::fetch_addr_t fill_addr,
    output icache_pkg::mem_block_t  fill_data
);

    // Idle, request held on the bus, waiting for data
    typedef enum logic [1:0] {
        MISS_IDLE,
        MISS_REQUEST,
        MISS_WAIT
    } miss_state_t;

    miss_state_t             state;
    icache_pkg::fetch_addr_t pending_addr;
    icache_pkg::mem_tag_t    pending_tag;
    logic                    start_miss;
    logic                    accepted;
    logic                    data_match;

    // New miss only taken while nothing is in flight
    assign start_miss = (state == MISS_IDLE) && miss_valid;
    // Nonzero tag while requesting is the accept
    assign accepted   = mem_req_valid && (mem_transaction_tag != '0);
    // Pending tag is nonzero here, so zero never matches
    assign data_match = (state == MISS_WAIT) && (mem_data_tag == pending_tag);

    assign mem_req_valid = (state == MISS_REQUEST);
    assign mem_req_addr  = pending_addr;
    assign fill_addr     = pending_addr;

    // ==============================
    // Control FSM
    // ==============================
    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= MISS_IDLE;
            fill_valid <= 1'b0;
        end else begin
            fill_valid <= data_match;
            case (state)
                MISS_IDLE: begin
                    if (miss_valid) begin
                        state <= MISS_REQUEST;
                    end
                end
                MISS_REQUEST: begin
                    if (accepted) begin
                        state <= MISS_WAIT;
                    end
                end
                // Leave after the fill pulse so the retry sees the new line
                MISS_WAIT: begin
                    if (fill_valid) begin
                        state <= MISS_IDLE;
                    end
                end
                default: begin
                    state <= MISS_IDLE;
                end
            endcase
        end
    end

    // Payload capture
    always_ff @(posedge clock) begin
        if (start_miss) begin
            pending_addr.raw <= {miss_addr.raw[`ICACHE_ADDR_BITS-1:`ICACHE_OFFSET_BITS],
                                 {`ICACHE_OFFSET_BITS{1'b0}}};
        end
        if (accepted) begin
            pending_tag <= mem_transaction_tag;
        end
        if (data_match) begin
            fill_data <= mem_data;
        end
    end

    // One fill per miss, the banks see a single write
    a_fill_single: assert property (@(posedge clock) disable iff (reset)
        fill_valid |=> !fill_valid);

endmodule

// ==== design/fetch_response.sv ====
`timescale 1ns/100ps

module fetch_response (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    read_valid_0,
    input  logic                    read_valid_1,
    input  icache_pkg::fetch_addr_t read_addr_0,
    input  icache_pkg::fetch_addr_t read_addr_1,
    input  logic                    bank_hit_0,
    input  logic                    bank_hit_1,
    input  icache_pkg::mem_block_t  bank_data_0,
    input  icache_pkg::mem_block_t  bank_data_1,
    input  logic                    bank_port_0,
    input  logic                    bank_port_1,
    output logic                    hit_0,
    output logic                    hit_1,
    output icache_pkg::mem_block_t  data_0,
    output icache_pkg::mem_block_t  data_1,
    output logic                    miss_valid,
    output icache_pkg::fetch_addr_t miss_addr
);

    logic                   p0_served;
    logic                   p1_served;
    logic                   p0_hit;
    logic                   p1_hit;
    logic                   p0_miss;
    logic                   p1_miss;
    icache_pkg::mem_block_t p0_data;
    icache_pkg::mem_block_t p1_data;

    // Pick each port's bank by its bank bit
    // A port counts only if that bank chose it
    always_comb begin
        if (read_addr_0.fields.bank) begin
            p0_served = read_valid_0 && !bank_port_1;
            p0_hit    = bank_hit_1;
            p0_data   = bank_data_1;
        end else begin
            p0_served = read_valid_0 && !bank_port_0;
            p0_hit    = bank_hit_0;
            p0_data   = bank_data_0;
        end
        if (read_addr_1.fields.bank) begin
            p1_served = read_valid_1 && bank_port_1;
            p1_hit    = bank_hit_1;
            p1_data   = bank_data_1;
        end else begin
            p1_served = read_valid_1 && bank_port_0;
            p1_hit    = bank_hit_0;
            p1_data   = bank_data_0;
        end
    end

    // Port 1 losing a conflict is not served, so never a miss
    assign p0_miss    = p0_served && !p0_hit;
    assign p1_miss    = p1_served && !p1_hit;
    assign miss_valid = p0_miss || p1_miss;
    assign miss_addr  = p0_miss ? read_addr_0 : read_addr_1;

    // Registered response, one cycle after the address
    always_ff @(posedge clock) begin
        if (reset) begin
            hit_0 <= 1'b0;
            hit_1 <= 1'b0;
        end else begin
            hit_0 <= p0_served && p0_hit;
            hit_1 <= p1_served && p1_hit;
        end
    end

    always_ff @(posedge clock) begin
        data_0 <= p0_data;
        data_1 <= p1_data;
    end

endmodule

// ==== design/icache_subsystem.sv ====
`timescale 1ns/100ps

module icache_subsystem (
    input  logic                    clock,
    input  logic                    reset,
    // Fetch side
    input  icache_pkg::fetch_addr_t read_addr_0,
    input  icache_pkg::fetch_addr_t read_addr_1,
    input  logic                    read_valid_0,
    input  logic                    read_valid_1,
    output logic                    hit_0,
    output logic                    hit_1,
    output icache_pkg::mem_block_t  data_0,
    output icache_pkg::mem_block_t  data_1,
    // Memory side
    output logic                    mem_req_valid,
    output icache_pkg::fetch_addr_t mem_req_addr,
    input  icache_pkg::mem_tag_t    mem_transaction_tag,
    input  icache_pkg::mem_tag_t    mem_data_tag,
    input  icache_pkg::mem_block_t  mem_data
);

    // Bank results
    logic                    bank_hit_0;
    logic                    bank_hit_1;
    logic                    bank_port_0;
    logic                    bank_port_1;
    icache_pkg::mem_block_t  bank_data_0;
    icache_pkg::mem_block_t  bank_data_1;

    // Miss and fill paths
    logic                    miss_valid;
    icache_pkg::fetch_addr_t miss_addr;
    logic                    fill_valid;
    icache_pkg::fetch_addr_t fill_addr;
    icache_pkg::mem_block_t  fill_data;

    // ==============================
    // Even bank, then odd bank
    // ==============================
    icache_bank u_bank_0 (
        .clock        (clock),
        .reset        (reset),
        .bank_id      (1'b0),
        .read_addr_0  (read_addr_0),
        .read_addr_1  (read_addr_1),
        .read_valid_0 (read_valid_0),
        .read_valid_1 (read_valid_1),
        .fill_valid   (fill_valid),
        .fill_addr    (fill_addr),
        .fill_data    (fill_data),
        .lookup_hit   (bank_hit_0),
        .lookup_data  (bank_data_0),
        .served_port  (bank_port_0)
    );

    icache_bank u_bank_1 (
        .clock        (clock),
        .reset        (reset),
        .bank_id      (1'b1),
        .read_addr_0  (read_addr_0),
        .read_addr_1  (read_addr_1),
        .read_valid_0 (read_valid_0),
        .read_valid_1 (read_valid_1),
        .fill_valid   (fill_valid),
        .fill_addr    (fill_addr),
        .fill_data    (fill_data),
        .lookup_hit   (bank_hit_1),
        .lookup_data  (bank_data_1),
        .served_port  (bank_port_1)
    );

    fetch_response u_fetch_response (
        .clock        (clock),
        .reset        (reset),
        .read_valid_0 (read_valid_0),
        .read_valid_1 (read_valid_1),
        .read_addr_0  (read_addr_0),
        .read_addr_1  (read_addr_1),
        .bank_hit_0   (bank_hit_0),
        .bank_hit_1   (bank_hit_1),
        .bank_data_0  (bank_data_0),
        .bank_data_1  (bank_data_1),
        .bank_port_0  (bank_port_0),
        .bank_port_1  (bank_port_1),
        .hit_0        (hit_0),
        .hit_1        (hit_1),
        .data_0       (data_0),
        .data_1       (data_1),
        .miss_valid   (miss_valid),
        .miss_addr    (miss_addr)
    );

    // Single outstanding miss toward memory
    miss_request u_miss_request (
        .clock               (clock),
        .reset               (reset),
        .miss_valid          (miss_valid),
        .miss_addr           (miss_addr),
        .mem_transaction_tag (mem_transaction_tag),
        .mem_data_tag        (mem_data_tag),
        .mem_data            (mem_data),
        .mem_req_valid       (mem_req_valid),
        .mem_req_addr        (mem_req_addr),
        .fill_valid          (fill_valid),
        .fill_addr           (fill_addr),
        .fill_data           (fill_data)
    );

endmodule

// ==== verification/icache_tb.sv ====
`timescale 1ns/100ps
`include "icache_defs.svh"

module icache_tb;

    // ==============================
    // DUT signals
    // ==============================
    logic                    clock;
    logic                    reset;
    icache_pkg::fetch_addr_t read_addr_0;
    icache_pkg::fetch_addr_t read_addr_1;
    logic                    read_valid_0;
    logic                    read_valid_1;
    logic                    hit_0;
    logic                    hit_1;
    icache_pkg::mem_block_t  data_0;
    icache_pkg::mem_block_t  data_1;
    logic                    mem_req_valid;
    icache_pkg::fetch_addr_t mem_req_addr;
    icache_pkg::mem_tag_t    mem_transaction_tag;
    icache_pkg::mem_tag_t    mem_data_tag;
    icache_pkg::mem_block_t  mem_data;

    // Memory model state
    logic                    hold_accept;
    logic [31:0]             lcg_state;
    icache_pkg::mem_tag_t    next_tag;

    // Bookkeeping
    string                   test_name;
    int                      error_count;
    int                      check_count;
    int                      test_errors;
    logic [15:0]             expect_addr_0;
    logic [15:0]             expect_addr_1;
    logic                    expect_valid_0;
    logic                    expect_valid_1;

    // Bank 0, bank 1, bank 0, bank 1
    localparam logic [15:0] addr_a = 16'h1235;
    localparam logic [15:0] addr_b = 16'h2a4e;
    localparam logic [15:0] addr_c = 16'h5670;
    localparam logic [15:0] addr_d = 16'h7a9b;

    icache_subsystem i_dut (
        .clock               (clock),
        .reset               (reset),
        .read_addr_0         (read_addr_0),
        .read_addr_1         (read_addr_1),
        .read_valid_0        (read_valid_0),
        .read_valid_1        (read_valid_1),
        .hit_0               (hit_0),
        .hit_1               (hit_1),
        .data_0              (data_0),
        .data_1              (data_1),
        .mem_req_valid       (mem_req_valid),
        .mem_req_addr        (mem_req_addr),
        .mem_transaction_tag (mem_transaction_tag),
        .mem_data_tag        (mem_data_tag),
        .mem_data            (mem_data)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // ==============================
    // Reference model
    // ==============================

    // Drop the byte offset
    function automatic logic [15:0] block_addr(input logic [15:0] addr);
        return {addr[15:`ICACHE_OFFSET_BITS], {`ICACHE_OFFSET_BITS{1'b0}}};
    endfunction

    // Block content, fixed by the block address alone
    function automatic icache_pkg::mem_block_t block_of(input logic [15:0] addr);
        logic [15:0] b;
        b = block_addr(addr);
        return {b ^ 16'hc3a5, ~b, b + 16'h1357, b[7:0], b[15:8]};
    endfunction

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // ==============================
    // Helpers
    // ==============================

    // Inputs change 2 ns after the edge, outputs read there too
    task automatic step();
        @(posedge clock);
        #2;
    endtask

    task automatic present(input logic [15:0] a0, input logic v0,
                           input logic [15:0] a1, input logic v1);
        read_addr_0.raw = a0;
        read_valid_0    = v0;
        read_addr_1.raw = a1;
        read_valid_1    = v1;
    endtask

    task automatic go_idle();
        read_valid_0 = 1'b0;
        read_valid_1 = 1'b0;
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        repeat (5) step();
        reset = 1'b0;
    endtask

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        check_count++;
        assert (actual === expected) else begin
            $display("CHECK FAILED %s %s: expected %h, actual %h",
                     test_name, what, expected, actual);
            error_count++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = error_count;
    endtask

    task automatic end_test();
        if (error_count == test_errors) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d errors", test_name, error_count - test_errors);
        end
    endtask

    // Bounded wait for hit_0
    task automatic wait_hit_0(input int limit, output bit ok);
        int cycles;
        ok     = 1'b0;
        cycles = 0;
        while (!ok && cycles < limit) begin
            step();
            cycles++;
            ok = hit_0;
        end
        assert (ok) else begin
            $display("%s: port 0 saw no hit within %0d cycles", test_name, limit);
            error_count++;
        end
    endtask

    // Bounded wait for a request to the given block
    task automatic wait_request(input logic [15:0] addr, input int limit, output bit ok);
        int cycles;
        ok     = 1'b0;
        cycles = 0;
        while (!ok && cycles < limit) begin
            step();
            cycles++;
            ok = mem_req_valid && (mem_req_addr.raw == addr);
        end
        assert (ok) else begin
            $display("%s: no memory request for %h within %0d cycles", test_name, addr, limit);
            error_count++;
        end
    endtask

    task automatic wait_request_low(input int limit);
        int cycles;
        cycles = 0;
        while (mem_req_valid && cycles < limit) begin
            step();
            cycles++;
        end
        assert (!mem_req_valid) else begin
            $display("%s: memory request still pending after %0d cycles", test_name, limit);
            error_count++;
        end
    endtask

    // Miss on port 0 and hold the address until the line arrives
    task automatic fill_block(input logic [15:0] addr, output bit ok);
        present(addr, 1'b1, 16'h0, 1'b0);
        wait_hit_0(50, ok);
        go_idle();
    endtask

    // ==============================
    // Memory model
    // ==============================
    initial begin : memory_model
        int                   delay;
        logic [15:0]          req_addr;
        icache_pkg::mem_tag_t tag;
        mem_transaction_tag = '0;
        mem_data_tag        = '0;
        mem_data            = '0;
        next_tag            = 4'd1;
        forever begin
            step();
            mem_transaction_tag = '0;
            mem_data_tag        = '0;
            if (mem_req_valid && !hold_accept) begin
                // Accept after 0 to 3 cycles
                delay = int'((lcg_next() >> 16) % 32'd4);
                repeat (delay) step();
                req_addr            = mem_req_addr.raw;
                tag                 = next_tag;
                next_tag            = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
                mem_transaction_tag = tag;
                step();
                mem_transaction_tag = '0;
                // Data 2 to 5 cycles after the accept edge
                delay = 2 + int'((lcg_next() >> 16) % 32'd4);
                repeat (delay - 1) step();
                mem_data_tag = tag;
                mem_data     = block_of(req_addr);
            end
        end
    end

    // ==============================
    // Response checker
    // ==============================
    // Negedge sampling, each hit belongs to the previous cycle's address
    initial begin : response_checker
        expect_valid_0 = 1'b0;
        expect_valid_1 = 1'b0;
        expect_addr_0  = '0;
        expect_addr_1  = '0;
        forever begin
            @(negedge clock);
            if (hit_0) begin
                assert (expect_valid_0) else begin
                    $display("%s: hit_0 raised without a valid read on port 0", test_name);
                    error_count++;
                end
                check_value("port 0 data", block_of(expect_addr_0), data_0);
            end
            if (hit_1) begin
                assert (expect_valid_1) else begin
                    $display("%s: hit_1 raised without a valid read on port 1", test_name);
                    error_count++;
                end
                check_value("port 1 data", block_of(expect_addr_1), data_1);
            end
            expect_addr_0  = read_addr_0.raw;
            expect_addr_1  = read_addr_1.raw;
            expect_valid_0 = read_valid_0;
            expect_valid_1 = read_valid_1;
        end
    end

    // ==============================
    // Test sequence
    // ==============================
    initial begin : test_sequence
        bit          ok;
        int          hit_count;
        logic [15:0] blocks [9];
        reset        = 1'b1;
        read_addr_0  = '0;
        read_addr_1  = '0;
        read_valid_0 = 1'b0;
        read_valid_1 = 1'b0;
        hold_accept  = 1'b0;
        lcg_state    = 32'h9377_f974;
        error_count  = 0;
        check_count  = 0;
        test_name    = "reset";
        apply_reset();

        begin_test("after_reset");
        check_value("hit_0", 64'(1'b0), 64'(hit_0));
        check_value("hit_1", 64'(1'b0), 64'(hit_1));
        check_value("mem_req_valid", 64'(1'b0), 64'(mem_req_valid));
        present(addr_a, 1'b1, 16'h0, 1'b0);
        step();
        check_value("first read hit_0", 64'(1'b0), 64'(hit_0));
        end_test();

        // Miss from the previous test is now on the memory bus
        begin_test("miss_and_fill");
        check_value("mem_req_valid", 64'(1'b1), 64'(mem_req_valid));
        check_value("mem_req_addr", 64'(block_addr(addr_a)), 64'(mem_req_addr.raw));
        wait_hit_0(50, ok);
        check_value("filled data", block_of(addr_a), data_0);
        go_idle();
        end_test();

        begin_test("two_banks");
        fill_block(addr_b, ok);
        present(addr_a, 1'b1, addr_b, 1'b1);
        step();
        check_value("hit_0", 64'(1'b1), 64'(hit_0));
        check_value("hit_1", 64'(1'b1), 64'(hit_1));
        check_value("data_0", block_of(addr_a), data_0);
        check_value("data_1", block_of(addr_b), data_1);
        go_idle();
        end_test();

        // Both in bank 0, port 1 loses and must not miss
        begin_test("bank_conflict");
        fill_block(addr_c, ok);
        present(addr_a, 1'b1, addr_c, 1'b1);
        for (int i = 0; i < 4; i++) begin
            step();
            check_value("hit_0", 64'(1'b1), 64'(hit_0));
            check_value("hit_1", 64'(1'b0), 64'(hit_1));
            check_value("mem_req_valid", 64'(1'b0), 64'(mem_req_valid));
        end
        go_idle();
        end_test();

        // Fresh bank 0, nine blocks into eight lines
        begin_test("replacement");
        apply_reset();
        for (int i = 0; i < 9; i++) begin
            blocks[i] = 16'h1005 + 16'(i) * 16'h20;
            fill_block(blocks[i], ok);
        end
        check_value("ninth block hit", 64'(1'b1), 64'(ok));
        // Probe misses must not refill until all nine are counted
        hold_accept = 1'b1;
        hit_count   = 0;
        for (int i = 0; i < 9; i++) begin
            present(blocks[i], 1'b1, 16'h0, 1'b0);
            step();
            if (hit_0) begin
                hit_count++;
            end
        end
        go_idle();
        hold_accept = 1'b0;
        check_value("resident blocks", 64'(8), 64'(hit_count));
        wait_request_low(40);
        end_test();

        begin_test("back_pressure");
        hold_accept = 1'b1;
        present(addr_d, 1'b1, 16'h0, 1'b0);
        wait_request(block_addr(addr_d), 40, ok);
        for (int i = 0; i < 8; i++) begin
            step();
            check_value("held mem_req_valid", 64'(1'b1), 64'(mem_req_valid));
            check_value("held mem_req_addr", 64'(block_addr(addr_d)), 64'(mem_req_addr.raw));
        end
        hold_accept = 1'b0;
        wait_hit_0(50, ok);
        check_value("filled data", block_of(addr_d), data_0);
        go_idle();
        end_test();

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+design
design/icache_pkg.sv
design/replace_lfsr.sv
design/icache_bank.sv
design/miss_request.sv
design/fetch_response.sv
design/icache_subsystem.sv
verification/icache_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = icache_tb
FILELIST  = filelist.f
BUILD_DIR = obj_dir
PASS_MSG  = All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Simulation output goes to the console and is searched for the pass message
run: compile
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
